// File: Makefile
# Verilator simulation of the custom-instruction subsystem

VERILATOR ?= verilator
TOP       ?= ciSubsystem_tb
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
SIMFLAGS  ?=

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) $(SIMFLAGS)

clean:
	rm -rf $(BUILD_DIR)

// File: all.f
verilog/ciPkg.sv
verilog/ciControl.sv
verilog/delayUnit.sv
verilog/profileUnit.sv
verilog/grayscaleUnit.sv
verilog/ciSubsystem.sv
tb/ciSubsystem_asserts.sv
tb/ciSubsystem_tb.sv

// File: tb/ciSubsystem_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module ciSubsystem_asserts (
  input wire                 s_systemClock,
  input wire                 s_pllLocked,
  input wire                 ready,
  input wire                 ciDone,
  input wire ciPkg::ciWord_t ciResult
);

  // nothing completes before the settle count has run out
  doneOnlyWhenReady: assert property (
    @(posedge s_systemClock) disable iff (!s_pllLocked) ciDone |-> ready
  ) else $error("ciDone high while ready is low");

  doneIsStrobe: assert property (
    @(posedge s_systemClock) disable iff (!s_pllLocked) ciDone |=> !ciDone
  ) else $error("ciDone held for more than one cycle");

  resultZeroWhenIdle: assert property (
    @(posedge s_systemClock) disable iff (!s_pllLocked) !ciDone |-> (ciResult == '0)
  ) else $error("ciResult not zero while ciDone is low"); // OR merge relies on this

endmodule

bind ciSubsystem ciSubsystem_asserts asserts_i (
  .s_systemClock(s_systemClock),
  .s_pllLocked(s_pllLocked),
  .ready(ready),
  .ciDone(ciDone),
  .ciResult(ciResult)
);

`default_nettype wire

// File: tb/ciSubsystem_tb.sv
`timescale 1ns/1ps
`default_nettype none

module ciSubsystem_tb;

  // run limit is twice the summed cycle budgets of the tests
  localparam int RESET_TEST_CYCLES   = 40;
  localparam int GRAY_TEST_CYCLES    = 100;
  localparam int DELAY_TEST_CYCLES   = 250;
  localparam int PROFILE_TEST_CYCLES = 560;
  localparam int UNKNOWN_TEST_CYCLES = 10;
  localparam int MAX_CYCLES = 2 * (RESET_TEST_CYCLES + GRAY_TEST_CYCLES + DELAY_TEST_CYCLES +
    PROFILE_TEST_CYCLES + UNKNOWN_TEST_CYCLES);

  logic             s_systemClock;
  logic             s_pllLocked;
  logic             ciStart;
  ciPkg::ciOpcode_t ciN;
  ciPkg::ciWord_t   ciDataA;
  ciPkg::ciWord_t   ciDataB;
  logic             stall;
  logic             busIdle;
  logic             ready;
  logic             ciDone;
  ciPkg::ciWord_t   ciResult;

  integer         seed;
  int             cycleCount = 0;
  logic           randomBus;
  ciPkg::ciWord_t expectedResults[$];
  int             expectedLatencies[$];
  int             startCycles[$];
  int             issuedCount;
  int             completedCount;
  ciPkg::ciWord_t lastResult;
  ciPkg::ciWord_t modelCount [4];
  logic [3:0]     modelEnable;
  logic [3:0]     countEvents;
  logic           profileCommand;

  ciSubsystem dut_i (
    .s_systemClock(s_systemClock),
    .s_pllLocked(s_pllLocked),
    .ciStart(ciStart),
    .ciN(ciN),
    .ciDataA(ciDataA),
    .ciDataB(ciDataB),
    .stall(stall),
    .busIdle(busIdle),
    .ready(ready),
    .ciDone(ciDone),
    .ciResult(ciResult)
  );

  always #10 s_systemClock = ~s_systemClock;

  task automatic failRun(input string why);
    $display("%s", why);
    $display("Test failures found");
    $fatal(1, "simulation stopped");
  endtask

  task automatic checkValue(input string what, input ciPkg::ciWord_t actual,
                            input ciPkg::ciWord_t expected);
    if (actual !== expected) begin
      failRun($sformatf("error at %0t: %s is %0h, expected %0h", $time, what, actual, expected));
    end
  endtask

  // expected result from the unit rules and the counter model
  function automatic ciPkg::ciWord_t referenceResult(ciPkg::ciOpcode_t op, ciPkg::ciWord_t a);
    int red;
    int green;
    int blue;
    case (op)
      ciPkg::CI_GRAY: begin
        red   = int'(a[15:11]) * 8;
        green = int'(a[10:5]) * 4;
        blue  = int'(a[4:0]) * 8;
        return ciPkg::ciWord_t'((red * int'(ciPkg::GRAY_RED_WEIGHT) +
          green * int'(ciPkg::GRAY_GREEN_WEIGHT) + blue * int'(ciPkg::GRAY_BLUE_WEIGHT)) / 256);
      end
      ciPkg::CI_PROFILE: return modelCount[a[1:0]];
      default:           return '0;
    endcase
  endfunction

  function automatic int referenceLatency(ciPkg::ciOpcode_t op, ciPkg::ciWord_t a);
    case (op)
      ciPkg::CI_GRAY:  return 2;
      ciPkg::CI_DELAY: return (a == '0) ? 1 : int'(a) * int'(ciPkg::CLOCKS_PER_MICROSECOND);
      default:         return 1;
    endcase
  endfunction

  // starts and returns on a falling edge
  task automatic runInstruction(input ciPkg::ciOpcode_t op, input ciPkg::ciWord_t a,
                                input ciPkg::ciWord_t b);
    expectedResults.push_back(referenceResult(op, a));
    expectedLatencies.push_back(referenceLatency(op, a));
    startCycles.push_back(cycleCount + 1); // index of the start edge
    issuedCount++;
    ciN     = op;
    ciDataA = a;
    ciDataB = b;
    ciStart = 1'b1;
    @(negedge s_systemClock);
    ciStart = 1'b0;
    wait (completedCount == issuedCount);
    @(negedge s_systemClock);
  endtask

  always @(posedge s_systemClock) begin
    cycleCount++;
    if (cycleCount >= MAX_CYCLES) begin
      failRun($sformatf("timeout after %0d cycles, the DUT stopped answering", cycleCount));
    end
  end

  // profile counter model updated on every rising edge
  always @(posedge s_systemClock or negedge s_pllLocked) begin
    if (!s_pllLocked) begin
      modelEnable = '0;
      for (int i = 0; i < 4; i++) begin
        modelCount[i] = '0;
      end
    end else begin
      profileCommand = ciStart && (ciN == ciPkg::CI_PROFILE);
      countEvents[0] = 1'b1; // every cycle
      countEvents[1] = stall;
      countEvents[2] = busIdle;
      countEvents[3] = !(stall || busIdle); // neither stalled nor idle
      for (int i = 0; i < 4; i++) begin
        if (profileCommand && ciDataB[8+i]) begin
          modelCount[i] = '0;
        end else if (modelEnable[i] && countEvents[i]) begin
          modelCount[i] = modelCount[i] + 32'd1;
        end
      end
      if (profileCommand) begin
        modelEnable = (modelEnable & ~ciDataB[7:4]) | ciDataB[3:0]; // takes effect next edge
      end
    end
  end

  always @(negedge s_systemClock) begin
    if (randomBus) begin
      {stall, busIdle} = 2'($random(seed));
    end
  end

  // compare every done against the oldest outstanding instruction
  always @(negedge s_systemClock) begin
    if (ciDone) begin
      if (expectedResults.size() == 0) begin
        failRun("ciDone arrived with no instruction outstanding");
      end else begin
        checkValue("ciResult", ciResult, expectedResults.pop_front());
        checkValue("latency in cycles", ciPkg::ciWord_t'(cycleCount - startCycles.pop_front() + 1),
          ciPkg::ciWord_t'(expectedLatencies.pop_front()));
        lastResult = ciResult;
        completedCount++;
      end
    end
  end

  initial begin
    ciPkg::ciWord_t pixel;
    ciPkg::ciWord_t firstRead;
    int             gap;
    s_systemClock  = 1'b0;
    s_pllLocked    = 1'b0;
    ciStart        = 1'b0;
    ciN            = ciPkg::CI_DELAY;
    ciDataA        = '0;
    ciDataB        = '0;
    stall          = 1'b0;
    busIdle        = 1'b0;
    seed           = 32'hd2d50a41;
    randomBus      = 1'b0;
    issuedCount    = 0;
    completedCount = 0;
    lastResult     = '0;

    repeat (5) @(negedge s_systemClock);
    checkValue("ready during reset", 32'(ready), 32'd0);
    s_pllLocked = 1'b1;
    // starts during the settle count must be ignored
    for (int i = 1; i <= ciPkg::RESET_SETTLE_CYCLES; i++) begin
      ciN     = ciPkg::CI_GRAY;
      ciStart = (i < 8);
      @(negedge s_systemClock);
      checkValue("ready while settling", 32'(ready), 32'(i == ciPkg::RESET_SETTLE_CYCLES));
    end

    repeat (20) begin
      pixel = $random(seed);
      runInstruction(ciPkg::CI_GRAY, pixel, '0);
    end

    runInstruction(ciPkg::CI_DELAY, 32'd0, '0);
    runInstruction(ciPkg::CI_DELAY, 32'd1, '0);
    runInstruction(ciPkg::CI_DELAY, 32'd3, '0);

    runInstruction(ciPkg::CI_PROFILE, 32'd0, 32'h0000_0f0f); // zero and enable all
    randomBus = 1'b1;
    for (int round = 0; round < 3; round++) begin
      for (int sel = 0; sel < 4; sel++) begin
        gap = int'({$random(seed)} % 16);
        repeat (gap) @(negedge s_systemClock);
        runInstruction(ciPkg::CI_PROFILE, ciPkg::ciWord_t'(sel), '0);
      end
    end
    runInstruction(ciPkg::CI_PROFILE, 32'd0, 32'h0000_00f0); // disable all
    repeat (5) @(negedge s_systemClock);
    runInstruction(ciPkg::CI_PROFILE, 32'd2, '0);
    firstRead = lastResult;
    repeat (7) @(negedge s_systemClock);
    runInstruction(ciPkg::CI_PROFILE, 32'd2, '0);
    checkValue("frozen counter read", lastResult, firstRead);
    randomBus = 1'b0;

    runInstruction(ciPkg::ciOpcode_t'(8'd3), 32'h1234_5678, 32'h9abc_def0);

    $display("All tests passed!");
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog/ciControl.sv
`timescale 1ns/1ps
`default_nettype none

module ciControl (
  input  wire                  s_systemClock,
  input  wire                  s_pllLocked,
  input  wire                  ciStart,
  input  wire ciPkg::ciOpcode_t ciN,
  input  wire                  delayDone,
  input  wire                  profileDone,
  input  wire                  grayDone,
  input  wire ciPkg::ciWord_t  delayResult,
  input  wire ciPkg::ciWord_t  profileResult,
  input  wire ciPkg::ciWord_t  grayResult,
  output logic                 ready,
  output logic                 delayStart,
  output logic                 profileStart,
  output logic                 grayStart,
  output logic                 ciDone,
  output ciPkg::ciWord_t       ciResult
);

  ciPkg::ciState_t                        state;
  logic [ciPkg::RESET_COUNT_WIDTH-1:0]    resetCount;
  logic                                   unknownStart;
  logic                                   unknownDone;

  // hold everything off until the clock has been stable for a while
  always_ff @(posedge s_systemClock or negedge s_pllLocked) begin
    if (!s_pllLocked) begin
      state      <= ciPkg::CI_RESETTING;
      resetCount <= '0;
    end else begin
      case (state)
        ciPkg::CI_RESETTING: begin
          if (resetCount == ciPkg::RESET_LAST_COUNT) begin
            state <= ciPkg::CI_READY;
          end else begin
            resetCount <= resetCount + 1'b1;
          end
        end
        default: begin
          state <= ciPkg::CI_READY; // stays here until the lock drops
        end
      endcase
    end
  end

  assign ready = (state == ciPkg::CI_READY);

  // single decode point for all units
  always_comb begin
    delayStart   = 1'b0;
    profileStart = 1'b0;
    grayStart    = 1'b0;
    unknownStart = 1'b0;
    if (ciStart && ready) begin
      case (ciN)
        ciPkg::CI_DELAY:   delayStart   = 1'b1;
        ciPkg::CI_PROFILE: profileStart = 1'b1;
        ciPkg::CI_GRAY:    grayStart    = 1'b1;
        default:           unknownStart = 1'b1;
      endcase
    end
  end

  // unknown opcodes finish next cycle with a zero result
  always_ff @(posedge s_systemClock or negedge s_pllLocked) begin
    if (!s_pllLocked) begin
      unknownDone <= 1'b0;
    end else begin
      unknownDone <= unknownStart;
    end
  end

  // units keep their result at zero when idle, so OR is enough
  assign ciDone   = delayDone | profileDone | grayDone | unknownDone;
  assign ciResult = delayResult | profileResult | grayResult;

endmodule

`default_nettype wire

// File: verilog/ciPkg.sv
`default_nettype none

package ciPkg;

  // operand and result words
  localparam int CI_DATA_WIDTH = 32;

  typedef logic [CI_DATA_WIDTH-1:0] ciWord_t;

  // custom instruction numbers as seen on ciN
  typedef enum logic [7:0] {
    CI_DELAY   = 8'd6,
    CI_PROFILE = 8'd12,
    CI_GRAY    = 8'd13
  } ciOpcode_t;

  typedef enum logic {
    CI_RESETTING, // settle count running
    CI_READY
  } ciState_t;

  // reset sequencing
  localparam int RESET_SETTLE_CYCLES = 16;
  localparam int RESET_COUNT_WIDTH   = $clog2(RESET_SETTLE_CYCLES);
  localparam logic [RESET_COUNT_WIDTH-1:0] RESET_LAST_COUNT =
    RESET_COUNT_WIDTH'(RESET_SETTLE_CYCLES - 1);

  // 50 MHz system clock
  localparam ciWord_t CLOCKS_PER_MICROSECOND = 32'd50;

  // profiler
  localparam int PROFILE_COUNTERS     = 4;
  localparam int PROFILE_SELECT_WIDTH = $clog2(PROFILE_COUNTERS);

  // luma weights, scaled so that they add up to 256
  localparam logic [7:0] GRAY_RED_WEIGHT   = 8'd54;
  localparam logic [7:0] GRAY_GREEN_WEIGHT = 8'd183;
  localparam logic [7:0] GRAY_BLUE_WEIGHT  = 8'd19;

  localparam int GRAY_COMPONENT_WIDTH = 8;
  // 8x8 products, the weighted sum still fits in 16 bits
  localparam int GRAY_PRODUCT_WIDTH   = 16;

endpackage

`default_nettype wire

// File: verilog/ciSubsystem.sv
`timescale 1ns/1ps
`default_nettype none

module ciSubsystem (
  input  wire                   s_systemClock,
  input  wire                   s_pllLocked,
  input  wire                   ciStart,
  input  wire ciPkg::ciOpcode_t ciN,
  input  wire ciPkg::ciWord_t   ciDataA,
  input  wire ciPkg::ciWord_t   ciDataB,
  input  wire                   stall,
  input  wire                   busIdle,
  output logic                  ready,
  output logic                  ciDone,
  output ciPkg::ciWord_t        ciResult
);

  logic           delayStart;
  logic           profileStart;
  logic           grayStart;
  logic           delayDone;
  logic           profileDone;
  logic           grayDone;
  ciPkg::ciWord_t delayResult;
  ciPkg::ciWord_t profileResult;
  ciPkg::ciWord_t grayResult;

  ciControl control (
    .s_systemClock(s_systemClock),
    .s_pllLocked(s_pllLocked),
    .ciStart(ciStart),
    .ciN(ciN),
    .delayDone(delayDone),
    .profileDone(profileDone),
    .grayDone(grayDone),
    .delayResult(delayResult),
    .profileResult(profileResult),
    .grayResult(grayResult),
    .ready(ready),
    .delayStart(delayStart),
    .profileStart(profileStart),
    .grayStart(grayStart),
    .ciDone(ciDone),
    .ciResult(ciResult)
  );

  // operand A is the microsecond count
  delayUnit delay (
    .s_systemClock(s_systemClock),
    .s_pllLocked(s_pllLocked),
    .start(delayStart),
    .microseconds(ciDataA),
    .done(delayDone),
    .result(delayResult)
  );

  profileUnit profiler (
    .s_systemClock(s_systemClock),
    .s_pllLocked(s_pllLocked),
    .start(profileStart),
    .stall(stall),
    .busIdle(busIdle),
    .counterSelect(ciDataA),
    .command(ciDataB),
    .done(profileDone),
    .result(profileResult)
  );

  grayscaleUnit gray (
    .s_systemClock(s_systemClock),
    .s_pllLocked(s_pllLocked),
    .start(grayStart),
    .pixel(ciDataA),
    .done(grayDone),
    .result(grayResult)
  );

endmodule

`default_nettype wire

// File: verilog/delayUnit.sv
`timescale 1ns/1ps
`default_nettype none

module delayUnit (
  input  wire                 s_systemClock,
  input  wire                 s_pllLocked,
  input  wire                 start,
  input  wire ciPkg::ciWord_t microseconds,
  output logic                done,
  output ciPkg::ciWord_t      result
);

  ciPkg::ciWord_t scaled;
  ciPkg::ciWord_t remaining;
  logic           busy;

  assign scaled = microseconds * ciPkg::CLOCKS_PER_MICROSECOND;

  // remaining counts the cycles left, done falls on the last one
  always_ff @(posedge s_systemClock or negedge s_pllLocked) begin
    if (!s_pllLocked) begin
      busy      <= 1'b0;
      remaining <= '0;
    end else if (start) begin
      busy      <= 1'b1;
      remaining <= (scaled == '0) ? ciPkg::ciWord_t'(1) : scaled; // zero still takes a cycle
    end else if (busy) begin
      remaining <= remaining - 1'b1;
      if (done) begin
        busy <= 1'b0;
      end
    end
  end

  assign done = busy && (remaining == ciPkg::ciWord_t'(1));

  // blocking delay only, nothing to return
  assign result = '0;

endmodule

`default_nettype wire

// File: verilog/grayscaleUnit.sv
`timescale 1ns/1ps
`default_nettype none

module grayscaleUnit (
  input  wire                 s_systemClock,
  input  wire                 s_pllLocked,
  input  wire                 start,
  input  wire ciPkg::ciWord_t pixel,
  output logic                done,
  output ciPkg::ciWord_t      result
);

  localparam int CW = ciPkg::GRAY_COMPONENT_WIDTH;
  localparam int PW = ciPkg::GRAY_PRODUCT_WIDTH;

  logic [CW-1:0] red;
  logic [CW-1:0] green;
  logic [CW-1:0] blue;
  logic [PW-1:0] redProduct;
  logic [PW-1:0] greenProduct;
  logic [PW-1:0] blueProduct;
  logic [PW-1:0] weightedSum;
  logic [CW-1:0] gray;
  logic          stage1Valid;

  // rgb565 fields widened to 8 bits
  assign red   = {pixel[15:11], 3'b000};
  assign green = {pixel[10:5], 2'b00};
  assign blue  = {pixel[4:0], 3'b000};

  always_ff @(posedge s_systemClock) begin
    redProduct   <= red * ciPkg::GRAY_RED_WEIGHT;
    greenProduct <= green * ciPkg::GRAY_GREEN_WEIGHT;
    blueProduct  <= blue * ciPkg::GRAY_BLUE_WEIGHT;
    gray         <= weightedSum[PW-1:PW-CW]; // divide by 256
  end

  assign weightedSum = redProduct + greenProduct + blueProduct;

  // valid bits follow the data, one pixel per cycle
  always_ff @(posedge s_systemClock or negedge s_pllLocked) begin
    if (!s_pllLocked) begin
      stage1Valid <= 1'b0;
      done        <= 1'b0;
    end else begin
      stage1Valid <= start;
      done        <= stage1Valid;
    end
  end

  assign result = done ? ciPkg::ciWord_t'(gray) : '0;

endmodule

`default_nettype wire

// File: verilog/profileUnit.sv
`timescale 1ns/1ps
`default_nettype none

module profileUnit (
  input  wire                 s_systemClock,
  input  wire                 s_pllLocked,
  input  wire                 start,
  input  wire                 stall,
  input  wire                 busIdle,
  input  wire ciPkg::ciWord_t counterSelect,
  input  wire ciPkg::ciWord_t command,
  output logic                done,
  output ciPkg::ciWord_t      result
);

  localparam int N = ciPkg::PROFILE_COUNTERS;

  logic [N-1:0]   enable;
  logic [N-1:0]   countEvent;
  logic [N-1:0]   setMask;
  logic [N-1:0]   clearMask;
  logic [N-1:0]   zeroMask;
  ciPkg::ciWord_t counters [N];
  ciPkg::ciWord_t sampled;

  // cycles, stalls, idle bus, busy and not stalled
  assign countEvent = {~stall & ~busIdle, busIdle, stall, 1'b1};

  assign setMask   = start ? command[N-1:0]     : '0;
  assign clearMask = start ? command[2*N-1:N]   : '0;
  assign zeroMask  = start ? command[3*N-1:2*N] : '0;

  always_ff @(posedge s_systemClock or negedge s_pllLocked) begin
    if (!s_pllLocked) begin
      enable <= '0;
      for (int i = 0; i < N; i++) begin
        counters[i] <= '0;
      end
    end else begin
      enable <= (enable & ~clearMask) | setMask;
      for (int i = 0; i < N; i++) begin
        if (zeroMask[i]) begin
          counters[i] <= '0;
        end else if (enable[i] && countEvent[i]) begin
          counters[i] <= counters[i] + 1'b1;
        end
      end
    end
  end

  // read value is the count before this edge's clear or increment
  always_ff @(posedge s_systemClock) begin
    if (start) begin
      sampled <= counters[counterSelect[ciPkg::PROFILE_SELECT_WIDTH-1:0]];
    end
  end

  always_ff @(posedge s_systemClock or negedge s_pllLocked) begin
    if (!s_pllLocked) begin
      done <= 1'b0;
    end else begin
      done <= start;
    end
  end

  assign result = done ? sampled : '0;

endmodule

`default_nettype wire
